/* Makefile */
SRCS := $(shell cat sim.f)

obj_dir/Vperiph_tb: sim.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module periph_tb -f sim.f

run: obj_dir/Vperiph_tb
	./obj_dir/Vperiph_tb | tee sim.log
	grep -qx "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

/* periph_assertions.sv */
// --------------------
// Bound checks on the top-level register port
//   ready low while an access is outstanding
//   response exactly two cycles after acceptance
//   interrupt output low in reset
// --------------------
module periph_assertions (
    input logic clk_i,
    input logic rst_i,
    input logic req_valid_i,
    input logic req_ready_i,
    input logic resp_valid_i,
    input logic irq_i
);

    logic accept;

    assign accept = req_valid_i && req_ready_i;

    busy_no_ready: assert property (@(posedge clk_i) disable iff (rst_i)
        accept |=> !req_ready_i)
        else $error("req_ready_o high while an access is outstanding");

    resp_two_cycles: assert property (@(posedge clk_i) disable iff (rst_i)
        accept |=> !resp_valid_i ##1 resp_valid_i)
        else $error("response not exactly two cycles after acceptance");

    irq_low_reset: assert property (@(posedge clk_i) rst_i |=> !irq_i)
        else $error("irq_o high during reset");

endmodule

bind periph_top periph_assertions i_assertions (
    .clk_i        ( clk_i        ),
    .rst_i        ( rst_i        ),
    .req_valid_i  ( req_valid_i  ),
    .req_ready_i  ( req_ready_o  ),
    .resp_valid_i ( resp_valid_o ),
    .irq_i        ( irq_o        )
);

/* periph_pkg.sv */
// --------------------
// Shared definitions for the interrupt and timer block
//   bus widths and region offset width
//   interrupt source numbering and priority width
//   address map of the PLIC and timer regions
//   routing target enum
// --------------------
package periph_pkg;

    // --------------------
    // Bus widths
    localparam int addr_w = 12;
    localparam int data_w = 32;
    localparam int off_w  = 8;    // Offset inside one 0x100 region

    // --------------------
    // Interrupt sources
    localparam int n_ext_irq      = 6;
    localparam int n_timer        = 2;
    localparam int n_src          = n_ext_irq + n_timer;
    localparam int timer_src_base = 7;    // Ids 1..6 are external
    localparam int prio_w         = 3;
    localparam int src_id_w       = 4;    // Id 0 means no source

    // --------------------
    // Address map
    localparam logic [addr_w-1:0] plic_base  = 12'h000;
    localparam logic [addr_w-1:0] timer_base = 12'h100;

    // PLIC offsets
    localparam logic [off_w-1:0] priority_off  = 8'h00;    // Plus 4 * id
    localparam logic [off_w-1:0] pending_off   = 8'h40;    // Read only
    localparam logic [off_w-1:0] enable_off    = 8'h44;
    localparam logic [off_w-1:0] threshold_off = 8'h48;
    localparam logic [off_w-1:0] claim_off     = 8'h4C;    // Read claims, write completes

    // Timer offsets, one stride per channel
    localparam logic [off_w-1:0] timer_stride = 8'h10;
    localparam logic [off_w-1:0] count_off    = 8'h00;
    localparam logic [off_w-1:0] compare_off  = 8'h04;
    localparam logic [off_w-1:0] ctrl_off     = 8'h08;    // Bit 0 is the enable

    typedef enum logic [1:0] {
        target_plic,
        target_timer,
        target_none
    } reg_target_e;

endpackage

/* periph_tb.sv */
// --------------------
// Testbench for the interrupt and timer block
//   clock, reset, register access tasks
//   claim reference model and value checker
//   watchdog and result report
// --------------------
module periph_tb;

    localparam int clk_period  = 4;
    localparam int n_tests     = 6;
    localparam int test_cycles = 200;
    localparam int seed        = 33016;
    localparam int n_src       = periph_pkg::n_src;

    logic                             clk = 1'b0;
    logic                             rst;
    logic                             req_valid;
    logic                             req_write;
    logic [periph_pkg::addr_w-1:0]    req_addr;
    logic [periph_pkg::data_w-1:0]    req_wdata;
    logic                             req_ready;
    logic                             resp_valid;
    logic [periph_pkg::data_w-1:0]    resp_rdata;
    logic                             resp_error;
    logic [periph_pkg::n_ext_irq-1:0] ext_irq;
    logic                             irq;

    int    cyc = 0;
    int    errors = 0;
    int    test_errors;
    int    tests_run = 0;
    int    tests_failed = 0;
    int    checks = 0;
    string cur_test = "reset";

    // Model state, index is the source id, bit and entry 0 unused
    logic [periph_pkg::prio_w-1:0] prio_m [n_src+1];
    logic [n_src:0]                en_m;
    logic [n_src:0]                pend_m;

    periph_top dut0 (
        .clk_i        ( clk        ),
        .rst_i        ( rst        ),
        .req_valid_i  ( req_valid  ),
        .req_write_i  ( req_write  ),
        .req_addr_i   ( req_addr   ),
        .req_wdata_i  ( req_wdata  ),
        .req_ready_o  ( req_ready  ),
        .resp_valid_o ( resp_valid ),
        .resp_rdata_o ( resp_rdata ),
        .resp_error_o ( resp_error ),
        .ext_irq_i    ( ext_irq    ),
        .irq_o        ( irq        )
    );

    always #(clk_period / 2) clk = ~clk;
    always @(posedge clk) cyc <= cyc + 1;

    // Highest priority pending enabled source, lowest id on ties
    function automatic int ref_claim(input logic [n_src:0] pend, input logic [n_src:0] en,
                                     input logic [periph_pkg::prio_w-1:0] prio [n_src+1]);
        int best;
        int best_prio;
        best      = 0;
        best_prio = 0;
        for (int id = 1; id <= n_src; id++) begin
            if (pend[id] && en[id] && int'(prio[id]) > best_prio) begin
                best      = id;
                best_prio = int'(prio[id]);
            end
        end
        return best;
    endfunction

    function automatic logic [periph_pkg::addr_w-1:0] plic_addr(input logic [7:0] off);
        return periph_pkg::plic_base + periph_pkg::addr_w'(off);
    endfunction

    function automatic logic [periph_pkg::addr_w-1:0] timer_addr(input int k,
                                                                 input logic [7:0] off);
        return periph_pkg::timer_base + periph_pkg::addr_w'(k * periph_pkg::timer_stride)
               + periph_pkg::addr_w'(off);
    endfunction

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            test_errors++;
            $display("error in %s: %s expected %h actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_errors = 0;
        tests_run++;
    endtask

    task automatic end_test();
        if (test_errors == 0) begin
            $display("test %s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: %0d mismatches", cur_test, test_errors);
        end
    endtask

    // Starts and returns one time unit after a rising edge
    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // One access; latency counts edges from acceptance to the edge that takes the response
    task automatic bus_access(input logic wr, input logic [periph_pkg::addr_w-1:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err, output int lat);
        int acc;
        acc       = -1;
        req_valid = 1'b1;
        req_write = wr;
        req_addr  = addr;
        req_wdata = wdata;
        while (acc < 0) begin
            if (req_ready) acc = cyc + 1;
            wait_cycles(1);
        end
        req_valid = 1'b0;
        while (!resp_valid) wait_cycles(1);    // Watchdog bounds this
        lat   = cyc + 1 - acc;
        rdata = resp_rdata;
        err   = resp_error;
    endtask

    task automatic reg_write(input logic [periph_pkg::addr_w-1:0] addr, input logic [31:0] data);
        logic [31:0] rd;
        logic        err;
        int          lat;
        bus_access(1'b1, addr, data, rd, err, lat);
        check($sformatf("write %h error flag", addr), 0, 32'(err));
        check($sformatf("write %h latency", addr), 2, lat);
    endtask

    task automatic reg_read(input logic [periph_pkg::addr_w-1:0] addr, output logic [31:0] data);
        logic err;
        int   lat;
        bus_access(1'b0, addr, '0, data, err, lat);
        check($sformatf("read %h error flag", addr), 0, 32'(err));
        check($sformatf("read %h latency", addr), 2, lat);
    endtask

    initial begin
        #(n_tests * test_cycles * clk_period);
        $display("watchdog expired in test %s, the run did not finish in time", cur_test);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        logic [31:0]                   rd;
        logic                          err;
        int                            lat;
        int                            exp_id;
        int                            ch;
        int                            thr;
        logic [n_src:0]                claimed;
        logic [periph_pkg::data_w-1:0] cmp [periph_pkg::n_timer];
        void'($urandom(seed));
        rst       = 1'b1;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        ext_irq   = '0;
        en_m      = '0;
        pend_m    = '0;
        for (int id = 0; id <= n_src; id++) prio_m[id] = '0;
        repeat (8) @(posedge clk);
        #1 rst = 1'b0;

        // --------------------
        start_test("register_readback");
        for (int id = 1; id <= n_src; id++) begin
            prio_m[id] = 3'($urandom_range(7, 1));
            reg_write(plic_addr(periph_pkg::priority_off + 8'(4 * id)), 32'(prio_m[id]));
        end
        en_m = 9'($urandom) & 9'h1FE;
        reg_write(plic_addr(periph_pkg::enable_off), 32'(en_m));
        thr = $urandom_range(7, 0);
        reg_write(plic_addr(periph_pkg::threshold_off), thr);
        for (int k = 0; k < periph_pkg::n_timer; k++) begin
            cmp[k] = $urandom;
            reg_write(timer_addr(k, periph_pkg::compare_off), cmp[k]);
        end
        for (int id = 1; id <= n_src; id++) begin
            reg_read(plic_addr(periph_pkg::priority_off + 8'(4 * id)), rd);
            check($sformatf("priority %0d", id), 32'(prio_m[id]), rd);
        end
        reg_read(plic_addr(periph_pkg::enable_off), rd);
        check("enable mask", 32'(en_m), rd);
        reg_read(plic_addr(periph_pkg::threshold_off), rd);
        check("threshold", thr, rd);
        for (int k = 0; k < periph_pkg::n_timer; k++) begin
            reg_read(timer_addr(k, periph_pkg::compare_off), rd);
            check($sformatf("compare %0d", k), cmp[k], rd);
        end
        reg_write(plic_addr(periph_pkg::threshold_off), 0);
        end_test();

        // --------------------
        start_test("unmapped_access");
        for (int i = 0; i < 4; i++) begin
            bus_access(1'(i % 2), 12'h200 + 12'($urandom_range(12'hDFF, 0)), $urandom,
                       rd, err, lat);
            check("error flag", 1, 32'(err));
            check("read data", 0, rd);
            check("latency", 2, lat);
        end
        end_test();

        // --------------------
        start_test("claim_order");
        for (int id = 1; id <= periph_pkg::n_ext_irq; id++) begin
            prio_m[id] = 3'($urandom_range(7, 1));
            reg_write(plic_addr(periph_pkg::priority_off + 8'(4 * id)), 32'(prio_m[id]));
        end
        en_m = (9'($urandom) & 9'h07E) | 9'h006;
        reg_write(plic_addr(periph_pkg::enable_off), 32'(en_m));
        ext_irq = 6'($urandom) | 6'h03;    // Sources 1 and 2 always active
        wait_cycles(2);
        pend_m = {2'b00, ext_irq, 1'b0};
        reg_read(plic_addr(periph_pkg::pending_off), rd);
        check("pending before claims", 32'(pend_m), rd);
        claimed = '0;
        do begin
            exp_id = ref_claim(pend_m, en_m, prio_m);
            reg_read(plic_addr(periph_pkg::claim_off), rd);
            check("claim id", exp_id, rd);
            if (exp_id != 0) begin
                pend_m[exp_id]  = 1'b0;
                claimed[exp_id] = 1'b1;
            end
        end while (exp_id != 0);
        reg_read(plic_addr(periph_pkg::pending_off), rd);
        check("pending after claims", 32'(pend_m), rd);
        end_test();

        // --------------------
        start_test("complete_rearm");
        // Source 1 stays high, source 2 drops, the rest at random
        ext_irq = (ext_irq & 6'($urandom) & ~6'h02) | 6'h01;
        for (int id = 1; id <= n_src; id++) begin
            if (claimed[id]) reg_write(plic_addr(periph_pkg::claim_off), id);
        end
        wait_cycles(2);
        pend_m = pend_m | (claimed & {2'b00, ext_irq, 1'b0});
        reg_read(plic_addr(periph_pkg::pending_off), rd);
        check("pending after complete", 32'(pend_m), rd);
        end_test();

        // --------------------
        start_test("threshold_irq");
        for (int i = 0; i < 4; i++) begin
            thr = (i == 3) ? 7 : $urandom_range(6, 0);
            reg_write(plic_addr(periph_pkg::threshold_off), thr);
            wait_cycles(3);
            exp_id = ref_claim(pend_m, en_m, prio_m);
            check($sformatf("irq_o at threshold %0d", thr),
                  32'(exp_id != 0 && int'(prio_m[exp_id]) > thr), 32'(irq));
        end
        reg_write(plic_addr(periph_pkg::threshold_off), 0);
        end_test();

        // --------------------
        start_test("timer_irq");
        ch      = $urandom_range(periph_pkg::n_timer - 1, 0);
        exp_id  = periph_pkg::timer_src_base + ch;
        ext_irq = '0;
        en_m    = '0;
        en_m[exp_id] = 1'b1;
        reg_write(plic_addr(periph_pkg::enable_off), 32'(en_m));
        reg_write(plic_addr(periph_pkg::priority_off + 8'(4 * exp_id)), 5);
        reg_write(timer_addr(ch, periph_pkg::count_off), 0);
        reg_write(timer_addr(ch, periph_pkg::compare_off), 20);
        reg_write(timer_addr(ch, periph_pkg::ctrl_off), 1);
        lat = 0;
        while (!irq && lat < 100) begin
            wait_cycles(1);
            lat++;
        end
        if (!irq) begin
            errors++;
            test_errors++;
            $display("%s: irq_o never rose after timer %0d was started", cur_test, ch);
        end
        reg_read(plic_addr(periph_pkg::claim_off), rd);
        check("timer claim id", exp_id, rd);
        reg_write(timer_addr(ch, periph_pkg::ctrl_off), 0);
        reg_write(plic_addr(periph_pkg::claim_off), exp_id);
        wait_cycles(2);
        reg_read(plic_addr(periph_pkg::claim_off), rd);
        check("claim after disable", 0, rd);
        end_test();

        $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* periph_top.sv */
// --------------------
// Interrupt and timer block top level
//   register router, PLIC core and timer bank
//   interrupt source vector
// --------------------
module periph_top (
    input  logic                             clk_i,
    input  logic                             rst_i,
    input  logic                             req_valid_i,
    input  logic                             req_write_i,
    input  logic [periph_pkg::addr_w-1:0]    req_addr_i,
    input  logic [periph_pkg::data_w-1:0]    req_wdata_i,
    output logic                             req_ready_o,
    output logic                             resp_valid_o,
    output logic [periph_pkg::data_w-1:0]    resp_rdata_o,
    output logic                             resp_error_o,
    input  logic [periph_pkg::n_ext_irq-1:0] ext_irq_i,
    output logic                             irq_o
);

    logic [periph_pkg::n_src-1:0]   irq_src;
    logic [periph_pkg::n_timer-1:0] timer_irq;

    reg_if plic_bus ();
    reg_if timer_bus ();

    // External inputs take the low ids, timers sit above them
    assign irq_src[periph_pkg::n_ext_irq-1:0] = ext_irq_i;
    assign irq_src[periph_pkg::timer_src_base-1 +: periph_pkg::n_timer] = timer_irq;

    reg_router i_router (
        .clk_i        ( clk_i        ),
        .rst_i        ( rst_i        ),
        .req_valid_i  ( req_valid_i  ),
        .req_write_i  ( req_write_i  ),
        .req_addr_i   ( req_addr_i   ),
        .req_wdata_i  ( req_wdata_i  ),
        .req_ready_o  ( req_ready_o  ),
        .resp_valid_o ( resp_valid_o ),
        .resp_rdata_o ( resp_rdata_o ),
        .resp_error_o ( resp_error_o ),
        .plic_o       ( plic_bus     ),
        .timer_o      ( timer_bus    )
    );

    plic_core i_plic (
        .clk_i ( clk_i    ),
        .rst_i ( rst_i    ),
        .bus_i ( plic_bus ),
        .src_i ( irq_src  ),
        .irq_o ( irq_o    )
    );

    timer_bank i_timer (
        .clk_i ( clk_i     ),
        .rst_i ( rst_i     ),
        .bus_i ( timer_bus ),
        .irq_o ( timer_irq )
    );

endmodule

/* plic_core.sv */
// --------------------
// PLIC core with one target
//   priority, enable, threshold and claim/complete registers
//   best pending source search and registered interrupt output
// --------------------
module plic_core (
    input  logic                         clk_i,
    input  logic                         rst_i,
    reg_if.periph                        bus_i,
    input  logic [periph_pkg::n_src-1:0] src_i,
    output logic                         irq_o
);

    logic [periph_pkg::prio_w-1:0]   prio_q [periph_pkg::n_src];
    logic [periph_pkg::n_src-1:0]    enable_q;
    logic [periph_pkg::prio_w-1:0]   threshold_q;
    logic [periph_pkg::n_src-1:0]    pending;
    logic [periph_pkg::src_id_w-1:0] best_id;
    logic [periph_pkg::prio_w-1:0]   best_prio;
    logic                            claim_valid;
    logic                            complete_valid;
    logic [periph_pkg::off_w-1:0]    prio_rel;
    logic [periph_pkg::off_w-3:0]    prio_idx;    // Source id of a priority access
    logic                            prio_hit;
    logic [periph_pkg::data_w-1:0]   rdata;
    logic                            resp_valid_q;
    logic [periph_pkg::data_w-1:0]   rdata_q;

    assign prio_rel = bus_i.addr - periph_pkg::priority_off;
    assign prio_idx = prio_rel[periph_pkg::off_w-1:2];
    assign prio_hit = (prio_rel[1:0] == 2'b00) && (prio_idx != '0) &&
                      (prio_idx <= periph_pkg::n_src);

    assign claim_valid    = bus_i.req_valid && !bus_i.write &&
                            (bus_i.addr == periph_pkg::claim_off);
    assign complete_valid = bus_i.req_valid && bus_i.write &&
                            (bus_i.addr == periph_pkg::claim_off);

    plic_gateway i_gateway (
        .clk_i            ( clk_i                                  ),
        .rst_i            ( rst_i                                  ),
        .src_i            ( src_i                                  ),
        .claim_i          ( best_id                                ),
        .claim_valid_i    ( claim_valid                            ),
        .complete_i       ( bus_i.wdata[periph_pkg::src_id_w-1:0]  ),
        .complete_valid_i ( complete_valid                         ),
        .pending_o        ( pending                                )
    );

    // Strict compare keeps the lowest id on ties, priority 0 never wins
    always_comb begin
        best_id   = '0;
        best_prio = '0;
        for (int i = 0; i < periph_pkg::n_src; i++) begin
            if (pending[i] && enable_q[i] && prio_q[i] > best_prio) begin
                best_id   = periph_pkg::src_id_w'(i + 1);
                best_prio = prio_q[i];
            end
        end
    end

    // --------------------
    // Register writes
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < periph_pkg::n_src; i++) begin
                prio_q[i] <= '0;
            end
            enable_q    <= '0;
            threshold_q <= '0;
        end else if (bus_i.req_valid && bus_i.write) begin
            for (int i = 0; i < periph_pkg::n_src; i++) begin
                if (prio_hit && prio_idx == (periph_pkg::off_w - 2)'(i + 1)) begin
                    prio_q[i] <= bus_i.wdata[periph_pkg::prio_w-1:0];
                end
            end
            if (bus_i.addr == periph_pkg::enable_off) begin
                enable_q <= bus_i.wdata[periph_pkg::n_src:1];    // Bit n is id n
            end
            if (bus_i.addr == periph_pkg::threshold_off) begin
                threshold_q <= bus_i.wdata[periph_pkg::prio_w-1:0];
            end
        end
    end

    // --------------------
    // Read mux, pending and enable read back with bit 0 as id 0
    always_comb begin
        rdata = '0;
        for (int i = 0; i < periph_pkg::n_src; i++) begin
            if (prio_hit && prio_idx == (periph_pkg::off_w - 2)'(i + 1)) begin
                rdata = periph_pkg::data_w'(prio_q[i]);
            end
        end
        case (bus_i.addr)
            periph_pkg::pending_off:   rdata = periph_pkg::data_w'({pending, 1'b0});
            periph_pkg::enable_off:    rdata = periph_pkg::data_w'({enable_q, 1'b0});
            periph_pkg::threshold_off: rdata = periph_pkg::data_w'(threshold_q);
            periph_pkg::claim_off:     rdata = periph_pkg::data_w'(best_id);
            default: ;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            resp_valid_q <= 1'b0;
            irq_o        <= 1'b0;
        end else begin
            resp_valid_q <= bus_i.req_valid;
            irq_o        <= best_prio > threshold_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (bus_i.req_valid) begin
            rdata_q <= bus_i.write ? '0 : rdata;
        end
    end

    assign bus_i.resp_valid = resp_valid_q;
    assign bus_i.rdata      = rdata_q;
    assign bus_i.error      = 1'b0;

endmodule

/* plic_gateway.sv */
// --------------------
// Level gateways for all interrupt sources
//   one pending and one in-flight bit per source
//   claim and complete by source id
// --------------------
module plic_gateway (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic [periph_pkg::n_src-1:0]    src_i,
    input  logic [periph_pkg::src_id_w-1:0] claim_i,
    input  logic                            claim_valid_i,
    input  logic [periph_pkg::src_id_w-1:0] complete_i,
    input  logic                            complete_valid_i,
    output logic [periph_pkg::n_src-1:0]    pending_o
);

    logic [periph_pkg::n_src-1:0] pending_q;
    logic [periph_pkg::n_src-1:0] inflight_q;

    assign pending_o = pending_q;

    // Bit i belongs to source id i+1
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pending_q  <= '0;
            inflight_q <= '0;
        end else begin
            for (int i = 0; i < periph_pkg::n_src; i++) begin
                if (claim_valid_i && claim_i == periph_pkg::src_id_w'(i + 1)) begin
                    pending_q[i]  <= 1'b0;
                    inflight_q[i] <= 1'b1;
                end else begin
                    if (complete_valid_i && complete_i == periph_pkg::src_id_w'(i + 1)) begin
                        inflight_q[i] <= 1'b0;    // Re-arms on the next cycle
                    end
                    if (src_i[i] && !inflight_q[i]) begin
                        pending_q[i] <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

/* reg_if.sv */
// --------------------
// Register bus between the router and one peripheral
//   request: valid, write, region offset, write data
//   response: valid, read data, error
// --------------------
interface reg_if;

    logic                          req_valid;
    logic                          write;
    logic [periph_pkg::off_w-1:0]  addr;     // Offset inside the region
    logic [periph_pkg::data_w-1:0] wdata;
    logic                          resp_valid;
    logic [periph_pkg::data_w-1:0] rdata;
    logic                          error;

    modport router (
        output req_valid, write, addr, wdata,
        input  resp_valid, rdata, error
    );

    modport periph (
        input  req_valid, write, addr, wdata,
        output resp_valid, rdata, error
    );

endinterface

/* reg_router.sv */
// --------------------
// Register router
//   accepts one access at a time from the top-level port
//   forwards it to the PLIC or timer region
//   answers unmapped addresses with an error
// --------------------
module reg_router (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  logic                          req_valid_i,
    input  logic                          req_write_i,
    input  logic [periph_pkg::addr_w-1:0] req_addr_i,
    input  logic [periph_pkg::data_w-1:0] req_wdata_i,
    output logic                          req_ready_o,
    output logic                          resp_valid_o,
    output logic [periph_pkg::data_w-1:0] resp_rdata_o,
    output logic                          resp_error_o,
    reg_if.router                         plic_o,
    reg_if.router                         timer_o
);

    logic                          accept;
    periph_pkg::reg_target_e       target;
    logic                          fwd_valid_q;
    periph_pkg::reg_target_e       fwd_target_q;
    logic                          fwd_write_q;
    logic [periph_pkg::off_w-1:0]  fwd_addr_q;
    logic [periph_pkg::data_w-1:0] fwd_wdata_q;
    logic                          none_resp_q;    // Error reply for unmapped access

    assign req_ready_o = !fwd_valid_q;
    assign accept      = req_valid_i && req_ready_o;

    // Region decode on the upper address bits
    always_comb begin
        if (req_addr_i[periph_pkg::addr_w-1:periph_pkg::off_w] ==
            periph_pkg::plic_base[periph_pkg::addr_w-1:periph_pkg::off_w]) begin
            target = periph_pkg::target_plic;
        end else if (req_addr_i[periph_pkg::addr_w-1:periph_pkg::off_w] ==
                     periph_pkg::timer_base[periph_pkg::addr_w-1:periph_pkg::off_w]) begin
            target = periph_pkg::target_timer;
        end else begin
            target = periph_pkg::target_none;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            fwd_valid_q <= 1'b0;
            none_resp_q <= 1'b0;
        end else begin
            fwd_valid_q <= accept;    // Forward stage lasts one cycle
            none_resp_q <= fwd_valid_q && (fwd_target_q == periph_pkg::target_none);
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            fwd_target_q <= target;
            fwd_write_q  <= req_write_i;
            fwd_addr_q   <= req_addr_i[periph_pkg::off_w-1:0];
            fwd_wdata_q  <= req_wdata_i;
        end
    end

    // --------------------
    // Forwarded request
    assign plic_o.req_valid  = fwd_valid_q && (fwd_target_q == periph_pkg::target_plic);
    assign plic_o.write      = fwd_write_q;
    assign plic_o.addr       = fwd_addr_q;
    assign plic_o.wdata      = fwd_wdata_q;
    assign timer_o.req_valid = fwd_valid_q && (fwd_target_q == periph_pkg::target_timer);
    assign timer_o.write     = fwd_write_q;
    assign timer_o.addr      = fwd_addr_q;
    assign timer_o.wdata     = fwd_wdata_q;

    // --------------------
    // Response merge, at most one source is valid
    assign resp_valid_o = plic_o.resp_valid || timer_o.resp_valid || none_resp_q;
    assign resp_error_o = (plic_o.resp_valid && plic_o.error) ||
                          (timer_o.resp_valid && timer_o.error) || none_resp_q;

    always_comb begin
        if (plic_o.resp_valid) begin
            resp_rdata_o = plic_o.rdata;
        end else if (timer_o.resp_valid) begin
            resp_rdata_o = timer_o.rdata;
        end else begin
            resp_rdata_o = '0;    // Also the unmapped reply
        end
    end

endmodule

/* sim.f */
periph_pkg.sv
reg_if.sv
reg_router.sv
plic_gateway.sv
plic_core.sv
timer_bank.sv
periph_top.sv
periph_assertions.sv
periph_tb.sv

/* timer_bank.sv */
// --------------------
// Compare timer channels
//   count, compare and control register per channel
//   level interrupt per channel
// --------------------
module timer_bank (
    input  logic                           clk_i,
    input  logic                           rst_i,
    reg_if.periph                          bus_i,
    output logic [periph_pkg::n_timer-1:0] irq_o
);

    logic [periph_pkg::data_w-1:0]  count_q   [periph_pkg::n_timer];
    logic [periph_pkg::data_w-1:0]  compare_q [periph_pkg::n_timer];
    logic [periph_pkg::n_timer-1:0] en_q;
    logic [periph_pkg::n_timer-1:0] wr_sel;
    logic [periph_pkg::off_w-1:0]   chan;
    logic [periph_pkg::off_w-1:0]   reg_off;
    logic [periph_pkg::data_w-1:0]  rdata;
    logic                           resp_valid_q;
    logic [periph_pkg::data_w-1:0]  rdata_q;

    assign chan    = bus_i.addr / periph_pkg::timer_stride;
    assign reg_off = bus_i.addr % periph_pkg::timer_stride;

    always_comb begin
        for (int k = 0; k < periph_pkg::n_timer; k++) begin
            wr_sel[k] = bus_i.req_valid && bus_i.write && (chan == periph_pkg::off_w'(k));
            irq_o[k]  = en_q[k] && (count_q[k] >= compare_q[k]);
        end
    end

    // --------------------
    // Channel registers
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int k = 0; k < periph_pkg::n_timer; k++) begin
                count_q[k]   <= '0;
                compare_q[k] <= '0;
            end
            en_q <= '0;
        end else begin
            for (int k = 0; k < periph_pkg::n_timer; k++) begin
                if (wr_sel[k] && reg_off == periph_pkg::count_off) begin
                    count_q[k] <= bus_i.wdata;    // Write wins over counting
                end else if (en_q[k]) begin
                    count_q[k] <= count_q[k] + 1'b1;
                end
                if (wr_sel[k] && reg_off == periph_pkg::compare_off) begin
                    compare_q[k] <= bus_i.wdata;
                end
                if (wr_sel[k] && reg_off == periph_pkg::ctrl_off) begin
                    en_q[k] <= bus_i.wdata[0];
                end
            end
        end
    end

    // Holes in the map read as zero
    always_comb begin
        rdata = '0;
        for (int k = 0; k < periph_pkg::n_timer; k++) begin
            if (chan == periph_pkg::off_w'(k)) begin
                case (reg_off)
                    periph_pkg::count_off:   rdata = count_q[k];
                    periph_pkg::compare_off: rdata = compare_q[k];
                    periph_pkg::ctrl_off:    rdata = periph_pkg::data_w'(en_q[k]);
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            resp_valid_q <= 1'b0;
        end else begin
            resp_valid_q <= bus_i.req_valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (bus_i.req_valid) begin
            rdata_q <= bus_i.write ? '0 : rdata;
        end
    end

    assign bus_i.resp_valid = resp_valid_q;
    assign bus_i.rdata      = rdata_q;
    assign bus_i.error      = 1'b0;

endmodule
